//--- common/soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_BE_W 4

// scratch RAM word index, 1024 words
`define RAM_ADDR_BITS 10

`define LED_W 8
`define KEY_W 2

// key debounce pacing
`define KEY_TICK_CYCLES 16
`define KEY_STABLE_TICKS 3

// address bits that pick the region
`define RGN_SEL_HI 31
`define RGN_SEL_LO 30

`endif

//--- common/soc_pkg.sv
`include "soc_macros.svh"

package soc_pkg;

  typedef logic [`SOC_ADDR_W-1:0] addr_t;
  typedef logic [`SOC_DATA_W-1:0] data_t;

  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  // decoded from address bits 31:30
  typedef enum logic [1:0]
  {
    RGN_RAM  = 2'b00,
    RGN_NONE = 2'b01, // unmapped
    RGN_LED  = 2'b10,
    RGN_KEYS = 2'b11  // read only
  } region_e;

  typedef enum logic [1:0]
  {
    ST_IDLE   = 2'd0,
    ST_ACCESS = 2'd1,
    ST_RESP   = 2'd2
  } mmc_state_e;

endpackage

//--- hdl/sample_tick_timer.sv
`include "soc_macros.svh"

module sample_tick_timer #(
  parameter int PERIOD = `KEY_TICK_CYCLES
) (
  input  logic clk,
  input  logic rst_n_i,
  output logic tick_o
);

  localparam int CNT_W = $clog2(PERIOD);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PERIOD - 1);

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      cnt_q <= '0;
    else if (cnt_q == CNT_LAST)
      cnt_q <= '0; // wrap
    else
      cnt_q <= cnt_q + 1'b1;
  end

  assign tick_o = (cnt_q == CNT_LAST);

  a_tick_single : assert property (@(posedge clk) disable iff (!rst_n_i)
    tick_o |=> !tick_o);

endmodule

//--- hdl/scratch_ram.sv
`include "soc_macros.svh"

module scratch_ram (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      sel_i,
  input  soc_pkg::bus_op_e          op_i,
  input  logic [`RAM_ADDR_BITS-1:0] addr_i,
  input  soc_pkg::data_t            wdata_i,
  input  logic [`SOC_BE_W-1:0]      be_i,
  output soc_pkg::data_t            rdata_o
);

  localparam int DEPTH = 1 << `RAM_ADDR_BITS;

  soc_pkg::data_t mem_q [DEPTH];
  soc_pkg::data_t rdata_q;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < DEPTH; i++)
        mem_q[i] <= '0;
    end
    else if (sel_i && op_i == soc_pkg::OP_WRITE)
    begin
      for (int b = 0; b < `SOC_BE_W; b++)
        if (be_i[b])
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8]; // enabled lanes only
    end
  end

  always_ff @(posedge clk)
  begin
    if (sel_i && op_i == soc_pkg::OP_READ)
      rdata_q <= mem_q[addr_i];
  end

  assign rdata_o = rdata_q;

  a_sel_known : assert property (@(posedge clk) disable iff (!rst_n_i)
    !$isunknown(sel_i));

endmodule

//--- hdl/gpio_regs.sv
`include "soc_macros.svh"

module gpio_regs (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                sel_i,
  input  soc_pkg::bus_op_e    op_i,
  input  logic                addr_i, // 0 led, 1 keys
  input  soc_pkg::data_t      wdata_i,
  input  logic                sample_tick_i,
  input  logic [`KEY_W-1:0]   key_i,
  output logic [`LED_W-1:0]   led_o,
  output soc_pkg::data_t      rdata_o
);

  localparam int CNT_W = $clog2(`KEY_STABLE_TICKS);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`KEY_STABLE_TICKS - 1);

  logic [`LED_W-1:0]            led_q;
  logic [`KEY_W-1:0]            key_meta_q;
  logic [`KEY_W-1:0]            key_sync_q;
  logic [`KEY_W-1:0]            key_deb_q;
  logic [`KEY_W-1:0][CNT_W-1:0] key_cnt_q;
  soc_pkg::data_t               rdata_q;

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      led_q <= '0;
    else if (sel_i && op_i == soc_pkg::OP_WRITE && !addr_i)
      led_q <= wdata_i[`LED_W-1:0];
  end

  // two flop synchronizer
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      key_meta_q <= '0;
      key_sync_q <= '0;
    end
    else
    begin
      key_meta_q <= key_i;
      key_sync_q <= key_meta_q;
    end
  end

  // accept a change only after enough differing samples in a row
  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      key_deb_q <= '0;
      key_cnt_q <= '0;
    end
    else if (sample_tick_i)
    begin
      for (int k = 0; k < `KEY_W; k++)
      begin
        if (key_sync_q[k] == key_deb_q[k])
          key_cnt_q[k] <= '0; // glitch gone, start over
        else if (key_cnt_q[k] == CNT_LAST)
        begin
          key_deb_q[k] <= key_sync_q[k];
          key_cnt_q[k] <= '0;
        end
        else
          key_cnt_q[k] <= key_cnt_q[k] + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sel_i && op_i == soc_pkg::OP_READ)
      rdata_q <= addr_i ? soc_pkg::data_t'(key_deb_q) : soc_pkg::data_t'(led_q);
  end

  assign led_o   = led_q;
  assign rdata_o = rdata_q;

endmodule

//--- mmc/mmc_fsm.sv
`include "soc_macros.svh"

module mmc_fsm (
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  soc_pkg::bus_op_e          req_op_i,
  input  soc_pkg::addr_t            req_addr_i,
  input  soc_pkg::data_t            req_wdata_i,
  input  logic [`SOC_BE_W-1:0]      req_be_i,
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output soc_pkg::data_t            rsp_rdata_o,
  output logic                      rsp_err_o,
  output logic                      ram_sel_o,
  output logic                      gpio_sel_o,
  output soc_pkg::bus_op_e          bus_op_o,
  output logic [`RAM_ADDR_BITS-1:0] word_addr_o,
  output soc_pkg::data_t            wdata_o,
  output logic [`SOC_BE_W-1:0]      be_o,
  input  soc_pkg::data_t            ram_rdata_i,
  input  soc_pkg::data_t            gpio_rdata_i
);

  soc_pkg::mmc_state_e       state_q;
  soc_pkg::mmc_state_e       state_d;
  soc_pkg::region_e          region_q;
  soc_pkg::bus_op_e          op_q;
  logic [`RAM_ADDR_BITS-1:0] widx_q;
  soc_pkg::data_t            wdata_q;
  logic [`SOC_BE_W-1:0]      be_q;
  logic                      rsp_valid_q;
  soc_pkg::data_t            rsp_rdata_q;
  logic                      rsp_err_q;
  logic                      req_fire;
  logic                      rsp_load;
  logic                      acc_err;
  soc_pkg::data_t            sel_rdata;

  assign req_fire = req_valid_i && (state_q == soc_pkg::ST_IDLE);
  assign rsp_load = (state_q == soc_pkg::ST_RESP) && !rsp_valid_q; // first RESP cycle

  // unmapped, or a write to the read-only keys
  assign acc_err = (region_q == soc_pkg::RGN_NONE) ||
                   (region_q == soc_pkg::RGN_KEYS && op_q == soc_pkg::OP_WRITE);

  assign sel_rdata = (region_q == soc_pkg::RGN_RAM) ? ram_rdata_i : gpio_rdata_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      soc_pkg::ST_IDLE:
        if (req_valid_i)
          state_d = soc_pkg::ST_ACCESS;
      soc_pkg::ST_ACCESS:
        state_d = soc_pkg::ST_RESP;
      soc_pkg::ST_RESP:
        if (rsp_valid_q && rsp_ready_i)
          state_d = soc_pkg::ST_IDLE;
      default:
        state_d = soc_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q     <= soc_pkg::ST_IDLE;
      region_q    <= soc_pkg::RGN_RAM;
      op_q        <= soc_pkg::OP_READ;
      rsp_valid_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (req_fire)
      begin
        region_q <= soc_pkg::region_e'(req_addr_i[`RGN_SEL_HI:`RGN_SEL_LO]);
        op_q     <= req_op_i;
      end
      if (rsp_load)
        rsp_valid_q <= 1'b1;
      else if (rsp_valid_q && rsp_ready_i)
        rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_fire)
    begin
      widx_q  <= req_addr_i[`RAM_ADDR_BITS+1:2];
      wdata_q <= req_wdata_i;
      be_q    <= req_be_i;
    end
    if (rsp_load)
    begin
      rsp_err_q   <= acc_err;
      rsp_rdata_q <= (op_q == soc_pkg::OP_READ && !acc_err) ? sel_rdata : '0;
    end
  end

  assign req_ready_o = (state_q == soc_pkg::ST_IDLE);
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_rdata_q;
  assign rsp_err_o   = rsp_err_q;

  assign ram_sel_o  = (state_q == soc_pkg::ST_ACCESS) && (region_q == soc_pkg::RGN_RAM);
  assign gpio_sel_o = (state_q == soc_pkg::ST_ACCESS) && !acc_err &&
                      (region_q == soc_pkg::RGN_LED || region_q == soc_pkg::RGN_KEYS);

  // gpio targets only look at bit 0
  assign word_addr_o = (region_q == soc_pkg::RGN_RAM) ? widx_q :
                       {{(`RAM_ADDR_BITS-1){1'b0}}, region_q == soc_pkg::RGN_KEYS};
  assign bus_op_o    = op_q;
  assign wdata_o     = wdata_q;
  assign be_o        = be_q;

  a_rsp_stable : assert property (@(posedge clk) disable iff (!rst_n_i)
    rsp_valid_o && !rsp_ready_i |=>
      rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_err_o));

  a_one_in_flight : assert property (@(posedge clk) disable iff (!rst_n_i)
    !(req_ready_o && rsp_valid_o));

  a_sel_onehot : assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({ram_sel_o, gpio_sel_o}));

endmodule

//--- hdl/soc_top.sv
`include "soc_macros.svh"

module soc_top (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  soc_pkg::bus_op_e     req_op_i,
  input  soc_pkg::addr_t       req_addr_i,
  input  soc_pkg::data_t       req_wdata_i,
  input  logic [`SOC_BE_W-1:0] req_be_i,
  output logic                 rsp_valid_o,
  input  logic                 rsp_ready_i,
  output soc_pkg::data_t       rsp_rdata_o,
  output logic                 rsp_err_o,
  output logic [`LED_W-1:0]    led_o,
  input  logic [`KEY_W-1:0]    key_i
);

  logic                      ram_sel;
  logic                      gpio_sel;
  soc_pkg::bus_op_e          bus_op;
  logic [`RAM_ADDR_BITS-1:0] word_addr;
  soc_pkg::data_t            wdata;
  logic [`SOC_BE_W-1:0]      be;
  soc_pkg::data_t            ram_rdata;
  soc_pkg::data_t            gpio_rdata;
  logic                      sample_tick;

  mmc_fsm u_mmc (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_op_i     (req_op_i),
    .req_addr_i   (req_addr_i),
    .req_wdata_i  (req_wdata_i),
    .req_be_i     (req_be_i),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_err_o    (rsp_err_o),
    .ram_sel_o    (ram_sel),
    .gpio_sel_o   (gpio_sel),
    .bus_op_o     (bus_op),
    .word_addr_o  (word_addr),
    .wdata_o      (wdata),
    .be_o         (be),
    .ram_rdata_i  (ram_rdata),
    .gpio_rdata_i (gpio_rdata)
  );

  scratch_ram u_ram (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .sel_i   (ram_sel),
    .op_i    (bus_op),
    .addr_i  (word_addr),
    .wdata_i (wdata),
    .be_i    (be),
    .rdata_o (ram_rdata)
  );

  sample_tick_timer #(.PERIOD(`KEY_TICK_CYCLES)) u_tick (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .tick_o  (sample_tick)
  );

  gpio_regs u_gpio (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .sel_i         (gpio_sel),
    .op_i          (bus_op),
    .addr_i        (word_addr[0]), // led/keys flag
    .wdata_i       (wdata),
    .sample_tick_i (sample_tick),
    .key_i         (key_i),
    .led_o         (led_o),
    .rdata_o       (gpio_rdata)
  );

endmodule

//--- verif/soc_top_tb.sv
module soc_top_tb;

  localparam int WAIT_LIMIT = 200;
  localparam int KEY_SETTLE = 120;

  logic             clk;
  logic             rst_n_i;
  logic             req_valid_i;
  logic             req_ready_o;
  soc_pkg::bus_op_e req_op_i;
  logic [31:0]      req_addr_i;
  logic [31:0]      req_wdata_i;
  logic [3:0]       req_be_i;
  logic             rsp_valid_o;
  logic             rsp_ready_i;
  logic [31:0]      rsp_rdata_o;
  logic             rsp_err_o;
  logic [7:0]       led_o;
  logic [1:0]       key_i;

  logic [7:0] led_model;
  logic [1:0] key_settled;
  int         cmd_count;

  soc_top dut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_be_i    (req_be_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o),
    .led_o       (led_o),
    .key_i       (key_i)
  );

  always
  begin
    #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Fail at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      $display("test failed");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("no %s within %0d cycles at %0t", what, WAIT_LIMIT, $time);
    $display("test failed");
    $fatal(1, "wait timed out");
  endtask

  task automatic report_bad_line(input string line);
    $display("cannot parse test data line: %s", line);
    $display("test failed");
    $fatal(1, "bad test data");
  endtask

  // inputs change 2 units after the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic bus_access(input soc_pkg::bus_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] be,
                            input logic [31:0] exp_rdata, input logic exp_err,
                            input logic check_rdata);
    int          waited;
    int          hold;
    logic [31:0] held_rdata;
    logic        held_err;
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_be_i    = be;
    waited      = 0;
    while (!req_ready_o)
    begin
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT)
        report_timeout("req_ready_o");
    end
    next_cycle(); // request taken on this edge
    req_valid_i = 1'b0;
    waited      = 0;
    while (!rsp_valid_o)
    begin
      check_value("req_ready_o", 32'(req_ready_o), 32'h0);
      next_cycle();
      waited++;
      if (waited > WAIT_LIMIT)
        report_timeout("rsp_valid_o");
    end
    check_value("response latency", waited, 32'd2);
    held_rdata = rsp_rdata_o;
    held_err   = rsp_err_o;
    hold       = $urandom % 4;
    repeat (hold)
    begin
      check_value("rsp_valid_o", 32'(rsp_valid_o), 32'h1);
      check_value("rsp_rdata_o", rsp_rdata_o, held_rdata);
      check_value("rsp_err_o", 32'(rsp_err_o), 32'(held_err));
      check_value("req_ready_o", 32'(req_ready_o), 32'h0);
      next_cycle();
    end
    rsp_ready_i = 1'b1;
    check_value("rsp_err_o", 32'(rsp_err_o), 32'(exp_err));
    if (check_rdata)
      check_value("rsp_rdata_o", rsp_rdata_o, exp_rdata);
    check_value("req_ready_o", 32'(req_ready_o), 32'h0);
    next_cycle(); // response handshake
    rsp_ready_i = 1'b0;
    check_value("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
    check_value("req_ready_o", 32'(req_ready_o), 32'h1);
  endtask

  initial
  begin
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    clk         = 1'b0;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = soc_pkg::OP_READ;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_be_i    = '0;
    rsp_ready_i = 1'b0;
    key_i       = '0;
    led_model   = '0;
    key_settled = '0;
    cmd_count   = 0;
    void'($urandom(79));
    repeat (8) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    check_value("rsp_valid_o", 32'(rsp_valid_o), 32'h0);
    check_value("req_ready_o", 32'(req_ready_o), 32'h1);
    check_value("led_o", 32'(led_o), 32'h0);

    fd = $fopen("verif/soc_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open verif/soc_testdata.txt");
      $display("test failed");
      $fatal(1, "no test data");
    end
    while ($fgets(line, fd) > 0)
    begin
      if (line.len() > 0)
      begin
        kind = line.getc(0);
        case (kind)
          "W":
          begin
            n = $sscanf(line, "W %h %h %h %h", a, b, c, d);
            if (n != 4)
              report_bad_line(line);
            bus_access(soc_pkg::OP_WRITE, a, b, c[3:0], 32'h0, d[0], d[0]);
            if (a[31:30] == 2'b10 && d[0] == 1'b0)
              led_model = b[7:0]; // led region keeps the low byte
            check_value("led_o", 32'(led_o), 32'(led_model));
            cmd_count++;
          end
          "R":
          begin
            n = $sscanf(line, "R %h %h %h", a, b, d);
            if (n != 3)
              report_bad_line(line);
            bus_access(soc_pkg::OP_READ, a, 32'h0, 4'h0, b, d[0], 1'b1);
            cmd_count++;
          end
          "K":
          begin
            n = $sscanf(line, "K %h", a);
            if (n != 1)
              report_bad_line(line);
            key_settled = a[1:0];
            key_i       = key_settled;
            repeat (KEY_SETTLE) next_cycle();
            cmd_count++;
          end
          "G":
          begin
            n = $sscanf(line, "G %h %d", a, b);
            if (n != 2)
              report_bad_line(line);
            key_i = a[1:0];
            repeat (b) next_cycle(); // short glitch
            key_i = key_settled;
            cmd_count++;
          end
          "#", "\n", "\r", " ":
            ;
          default:
            report_bad_line(line);
        endcase
      end
    end
    $fclose(fd);

    if (cmd_count == 0)
    begin
      $display("test data held no commands");
      $display("test failed");
      $fatal(1, "empty test data");
    end
    else
    begin
      $display("test passed");
      $finish;
    end
  end

endmodule

//--- verif/soc_testdata.txt
# W addr wdata be err | R addr rdata err | K keys
# G keys cycles, a glitch that returns to the settled keys; all hex except cycles
W 00000010 11223344 f 0
R 00000010 11223344 0
W 00000010 aabbccdd 5 0
R 00000010 11bb33dd 0
R 12345010 11bb33dd 0
W 00000ffc cafef00d 8 0
R 3ffffffc ca000000 0
W 00000010 ffffffff 0 0
R 00000010 11bb33dd 0
W 00000100 0000ab00 2 0
R 00000100 0000ab00 0
R 00000020 00000000 0
W 80000000 000000a5 f 0
R 80000000 000000a5 0
W 80000004 12345678 f 0
R 80000000 00000078 0
R c0000000 00000000 0
R 40000000 00000000 1
W 40000010 deadbeef f 1
R 00000010 11bb33dd 0
W c0000000 00000003 f 1
R c0000000 00000000 0
R 80000000 00000078 0
K 1
R c0000000 00000001 0
K 3
R c0000000 00000003 0
G 0 8
R c0000000 00000003 0
K 2
W c0000000 00000001 f 1
R c0000000 00000002 0
G 1 8
R c0000000 00000002 0
K 0
R c0000000 00000000 0

//--- soc_top.f
+incdir+common
common/soc_pkg.sv
hdl/sample_tick_timer.sv
hdl/scratch_ram.sv
hdl/gpio_regs.sv
mmc/mmc_fsm.sv
hdl/soc_top.sv
verif/soc_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, then run from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module soc_top_tb -f soc_top.f -o soc_top_sim \
  && ./obj_dir/soc_top_sim \
  || { echo "simulation failed" >&2; exit 1; }
